// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= map_render_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= *** TEST PASSED ***

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv hw/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/map_layout_pkg.sv ====
`include "map_macros.svh"

package map_layout_pkg;

    typedef enum logic [2:0] {
        TILE_SOLID,
        TILE_RED_RIVER,
        TILE_BLUE_RIVER,
        TILE_RED_DOOR,
        TILE_BLUE_DOOR
    } tile_kind_t;

    // one terrain rectangle on the 320x240 game grid
    typedef struct packed {
        logic [`COORD_W-1:0] pivot_h;
        logic [`COORD_W-1:0] pivot_v;
        logic [`COORD_W-1:0] width;
        logic [`COORD_W-1:0] height;
        logic [`COORD_W-1:0] mem_pivot_h;
        logic [`COORD_W-1:0] mem_pivot_v;
        tile_kind_t          kind;
    } tile_rect_t;

    // index 0 wins when rectangles overlap
    // columns: pivot h, pivot v, width, height, mem pivot h, mem pivot v, kind
    parameter tile_rect_t LAYOUT [`NUM_TILES] = '{
        // ceiling
        '{10'd0,   10'd0,   10'd320, 10'd10,  10'd0,   10'd220, TILE_SOLID},
        // rivers sit on top of the floor
        '{10'd150, 10'd230, 10'd40,  10'd6,   10'd0,   10'd65,  TILE_RED_RIVER},
        '{10'd210, 10'd230, 10'd40,  10'd6,   10'd55,  10'd70,  TILE_BLUE_RIVER},
        // floor
        '{10'd0,   10'd230, 10'd320, 10'd10,  10'd0,   10'd220, TILE_SOLID},
        // left and right boundary
        '{10'd0,   10'd10,  10'd10,  10'd220, 10'd305, 10'd10,  TILE_SOLID},
        '{10'd310, 10'd10,  10'd10,  10'd220, 10'd305, 10'd10,  TILE_SOLID},
        // walls 1 to 5
        '{10'd10,  10'd182, 10'd230, 10'd8,   10'd50,  10'd215, TILE_SOLID},
        '{10'd90,  10'd139, 10'd220, 10'd8,   10'd0,   10'd220, TILE_SOLID},
        '{10'd85,  10'd96,  10'd185, 10'd8,   10'd0,   10'd220, TILE_SOLID},
        '{10'd160, 10'd89,  10'd50,  10'd8,   10'd0,   10'd220, TILE_SOLID},
        '{10'd110, 10'd48,  10'd200, 10'd8,   10'd0,   10'd220, TILE_SOLID},
        // exit doors
        '{10'd250, 10'd19,  10'd23,  10'd29,  10'd0,   10'd89,  TILE_RED_DOOR},
        '{10'd280, 10'd19,  10'd23,  10'd29,  10'd32,  10'd89,  TILE_BLUE_DOOR}
    };

endpackage

// ==== hw/map_macros.svh ====
`ifndef MAP_MACROS_SVH
`define MAP_MACROS_SVH

// scan and game coordinate width
`define COORD_W 10

// sprite memory address width and row pitch in words
`define ADDR_W 17
`define MEM_PITCH 320

// address output when the pixel hits no tile
`define BLANK_ADDR 12900

// entries in the terrain layout table
`define NUM_TILES 13

// player box size in game pixels
`define PLAYER_W 10
`define PLAYER_H 16

`endif

// ==== hw/map_render.sv ====
`timescale 1ns/1ns
`include "map_macros.svh"

module map_render (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     en,
    input  logic [`COORD_W-1:0]      vga_h,
    input  logic [`COORD_W-1:0]      vga_v,
    input  logic [`COORD_W-1:0]      p1_x,
    input  logic [`COORD_W-1:0]      p1_y,
    input  logic [`COORD_W-1:0]      p2_x,
    input  logic [`COORD_W-1:0]      p2_y,
    output sprite_pkg::sprite_addr_t addr,
    output logic                     p1_land,
    output logic                     p1_collision,
    output logic                     p1_hazard,
    output logic                     p1_at_door,
    output logic                     p2_land,
    output logic                     p2_collision,
    output logic                     p2_hazard,
    output logic                     p2_at_door
);

    logic [`NUM_TILES-1:0]    tile_hit;
    sprite_pkg::sprite_addr_t tile_addr [`NUM_TILES];

    // stage 1, one hit test per layout entry
    for (genvar i = 0; i < `NUM_TILES; i++) begin : g_tile
        terrain_tile #(
            .PIVOT_H     (map_layout_pkg::LAYOUT[i].pivot_h),
            .PIVOT_V     (map_layout_pkg::LAYOUT[i].pivot_v),
            .WIDTH       (map_layout_pkg::LAYOUT[i].width),
            .HEIGHT      (map_layout_pkg::LAYOUT[i].height),
            .MEM_PIVOT_H (map_layout_pkg::LAYOUT[i].mem_pivot_h),
            .MEM_PIVOT_V (map_layout_pkg::LAYOUT[i].mem_pivot_v)
        ) u_tile (
            .clk   (clk),
            .rst_n (rst_n),
            .en    (en),
            .vga_h (vga_h),
            .vga_v (vga_v),
            .hit   (tile_hit[i]),
            .addr  (tile_addr[i])
        );
    end

    // stage 2, first hit wins
    tile_priority_sel #(
        .N (`NUM_TILES)
    ) u_sel (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .tile_hit  (tile_hit),
        .tile_addr (tile_addr),
        .addr      (addr)
    );

    // player state runs beside the pixel pipeline
    obj_state_ctrl u_osc (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .p1_x         (p1_x),
        .p1_y         (p1_y),
        .p2_x         (p2_x),
        .p2_y         (p2_y),
        .p1_land      (p1_land),
        .p1_collision (p1_collision),
        .p1_hazard    (p1_hazard),
        .p1_at_door   (p1_at_door),
        .p2_land      (p2_land),
        .p2_collision (p2_collision),
        .p2_hazard    (p2_hazard),
        .p2_at_door   (p2_at_door)
    );

endmodule

// ==== hw/obj_state_ctrl.sv ====
`timescale 1ns/1ns
`include "map_macros.svh"

module obj_state_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en,
    input  logic [`COORD_W-1:0] p1_x,
    input  logic [`COORD_W-1:0] p1_y,
    input  logic [`COORD_W-1:0] p2_x,
    input  logic [`COORD_W-1:0] p2_y,
    output logic                p1_land,
    output logic                p1_collision,
    output logic                p1_hazard,
    output logic                p1_at_door,
    output logic                p2_land,
    output logic                p2_collision,
    output logic                p2_hazard,
    output logic                p2_at_door
);

    // flag vector order is {land, collision, hazard, at_door}
    logic [3:0] p1_flags;
    logic [3:0] p2_flags;

    // tests one player box against every layout entry
    function automatic logic [3:0] player_flags(
        input logic [`COORD_W-1:0]     x,
        input logic [`COORD_W-1:0]     y,
        input map_layout_pkg::tile_kind_t hazard_kind,
        input map_layout_pkg::tile_kind_t door_kind
    );
        logic [`COORD_W:0]       box_r;
        logic [`COORD_W:0]       box_b;
        logic [`COORD_W:0]       rect_r;
        logic [`COORD_W:0]       rect_b;
        logic                    ovl_h;
        logic                    ovl_v;
        logic                    land;
        logic                    coll;
        logic                    hazard;
        logic                    door;
        map_layout_pkg::tile_rect_t r;
        box_r  = {1'b0, x} + (`COORD_W+1)'(`PLAYER_W);
        box_b  = {1'b0, y} + (`COORD_W+1)'(`PLAYER_H);
        land   = 1'b0;
        coll   = 1'b0;
        hazard = 1'b0;
        door   = 1'b0;
        for (int i = 0; i < `NUM_TILES; i++) begin
            r      = map_layout_pkg::LAYOUT[i];
            rect_r = {1'b0, r.pivot_h} + {1'b0, r.width};
            rect_b = {1'b0, r.pivot_v} + {1'b0, r.height};
            // strict on both sides, so touching edges do not overlap
            ovl_h  = ({1'b0, x} < rect_r) && ({1'b0, r.pivot_h} < box_r);
            ovl_v  = ({1'b0, y} < rect_b) && ({1'b0, r.pivot_v} < box_b);
            if (r.kind == map_layout_pkg::TILE_SOLID) begin
                coll = coll | (ovl_h & ovl_v);
                // feet resting exactly on the top edge
                land = land | (ovl_h & (box_b == {1'b0, r.pivot_v}));
            end
            if (r.kind == hazard_kind) begin
                hazard = hazard | (ovl_h & ovl_v);
            end
            if (r.kind == door_kind) begin
                door = door | (ovl_h & ovl_v);
            end
        end
        return {land, coll, hazard, door};
    endfunction

    // player 1 is red, player 2 is blue
    assign p1_flags = player_flags(p1_x, p1_y,
                                   map_layout_pkg::TILE_BLUE_RIVER,
                                   map_layout_pkg::TILE_RED_DOOR);
    assign p2_flags = player_flags(p2_x, p2_y,
                                   map_layout_pkg::TILE_RED_RIVER,
                                   map_layout_pkg::TILE_BLUE_DOOR);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {p1_land, p1_collision, p1_hazard, p1_at_door} <= 4'b0;
            {p2_land, p2_collision, p2_hazard, p2_at_door} <= 4'b0;
        end else if (en) begin
            {p1_land, p1_collision, p1_hazard, p1_at_door} <= p1_flags;
            {p2_land, p2_collision, p2_hazard, p2_at_door} <= p2_flags;
        end
    end

endmodule

// ==== hw/sprite_pkg.sv ====
`include "map_macros.svh"

package sprite_pkg;

    typedef logic [`ADDR_W-1:0] sprite_addr_t;

    // word address of game pixel (h, v) inside a tile,
    // relative to where the tile's art sits in sprite memory
    function automatic sprite_addr_t tile_addr(
        input logic [`COORD_W-1:0] h,
        input logic [`COORD_W-1:0] v,
        input logic [`COORD_W-1:0] pivot_h,
        input logic [`COORD_W-1:0] pivot_v,
        input logic [`COORD_W-1:0] mem_pivot_h,
        input logic [`COORD_W-1:0] mem_pivot_v
    );
        sprite_addr_t col;
        sprite_addr_t row;
        col = sprite_addr_t'(h) - sprite_addr_t'(pivot_h) + sprite_addr_t'(mem_pivot_h);
        row = sprite_addr_t'(v) - sprite_addr_t'(pivot_v) + sprite_addr_t'(mem_pivot_v);
        return sprite_addr_t'(row * `MEM_PITCH) + col;
    endfunction

endpackage

// ==== hw/terrain_tile.sv ====
`timescale 1ns/1ns
`include "map_macros.svh"

module terrain_tile #(
    parameter logic [`COORD_W-1:0] PIVOT_H     = '0,
    parameter logic [`COORD_W-1:0] PIVOT_V     = '0,
    parameter logic [`COORD_W-1:0] WIDTH       = '0,
    parameter logic [`COORD_W-1:0] HEIGHT      = '0,
    parameter logic [`COORD_W-1:0] MEM_PIVOT_H = '0,
    parameter logic [`COORD_W-1:0] MEM_PIVOT_V = '0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  logic [`COORD_W-1:0]    vga_h,
    input  logic [`COORD_W-1:0]    vga_v,
    output logic                   hit,
    output sprite_pkg::sprite_addr_t addr
);

    // one bit wider so the far edge never wraps
    localparam logic [`COORD_W:0] END_H = PIVOT_H + WIDTH;
    localparam logic [`COORD_W:0] END_V = PIVOT_V + HEIGHT;

    logic [`COORD_W-1:0]      h;
    logic [`COORD_W-1:0]      v;
    logic                     in_rect;
    sprite_pkg::sprite_addr_t addr_d;

    // 640x480 scan to 320x240 grid
    assign h = vga_h >> 1;
    assign v = vga_v >> 1;

    // half-open rectangle test
    assign in_rect = (h >= PIVOT_H) && ({1'b0, h} < END_H) &&
                     (v >= PIVOT_V) && ({1'b0, v} < END_V);

    assign addr_d = in_rect ?
        sprite_pkg::tile_addr(h, v, PIVOT_H, PIVOT_V, MEM_PIVOT_H, MEM_PIVOT_V) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit  <= 1'b0;
            addr <= '0;
        end else if (en) begin
            hit  <= in_rect;
            addr <= addr_d;
        end
    end

endmodule

// ==== hw/tile_priority_sel.sv ====
`timescale 1ns/1ns
`include "map_macros.svh"

module tile_priority_sel #(
    parameter int N = `NUM_TILES
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     en,
    input  logic [N-1:0]             tile_hit,
    input  sprite_pkg::sprite_addr_t tile_addr [N],
    output sprite_pkg::sprite_addr_t addr
);

    localparam sprite_pkg::sprite_addr_t BLANK = sprite_pkg::sprite_addr_t'(`BLANK_ADDR);

    sprite_pkg::sprite_addr_t sel_addr;

    // walk from the lowest priority up so index 0 is written last
    always_comb begin
        sel_addr = BLANK;
        for (int i = N - 1; i >= 0; i--) begin
            if (tile_hit[i]) begin
                sel_addr = tile_addr[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr <= BLANK;
        end else if (en) begin
            addr <= sel_addr;
        end
    end

endmodule

// ==== list.f ====
+incdir+hw
hw/map_layout_pkg.sv
hw/sprite_pkg.sv
hw/terrain_tile.sv
hw/tile_priority_sel.sv
hw/obj_state_ctrl.sv
hw/map_render.sv
verif/map_render_chk.sv
verif/map_render_tb.sv

// ==== verif/map_render_chk.sv ====
`timescale 1ns/1ns
`include "map_macros.svh"

module map_render_chk (
    input logic                clk,
    input logic                rst_n,
    input logic                en,
    input logic [`ADDR_W-1:0]  addr,
    input logic                p1_land,
    input logic                p1_collision,
    input logic                p1_hazard,
    input logic                p1_at_door,
    input logic                p2_land,
    input logic                p2_collision,
    input logic                p2_hazard,
    input logic                p2_at_door
);

    typedef logic [`ADDR_W-1:0] addr_t;

    localparam addr_t BLANK = addr_t'(`BLANK_ADDR);
    // sprite memory holds one 320x240 sheet
    localparam addr_t MEM_WORDS = addr_t'(`MEM_PITCH * 240);

    int unsigned fail_count = 0;
    logic [7:0]  flags;

    assign flags = {p1_land, p1_collision, p1_hazard, p1_at_door,
                    p2_land, p2_collision, p2_hazard, p2_at_door};

    // sampled mid-cycle, reset is asynchronous
    a_reset_values: assert property (@(negedge clk) !rst_n |-> (addr == BLANK && flags == '0))
        else begin
            $error("outputs left their reset values while rst_n was low");
            fail_count++;
        end

    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(en) |-> $stable(addr))
        else begin
            $error("addr changed after an edge with en low");
            fail_count++;
        end

    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n) addr < MEM_WORDS)
        else begin
            $error("addr points past the end of sprite memory");
            fail_count++;
        end

endmodule

bind map_render map_render_chk u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .en           (en),
    .addr         (addr),
    .p1_land      (p1_land),
    .p1_collision (p1_collision),
    .p1_hazard    (p1_hazard),
    .p1_at_door   (p1_at_door),
    .p2_land      (p2_land),
    .p2_collision (p2_collision),
    .p2_hazard    (p2_hazard),
    .p2_at_door   (p2_at_door)
);

// ==== verif/map_render_tb.sv ====
`timescale 1ns/1ns
`include "map_macros.svh"

module map_render_tb;

    typedef logic [`COORD_W-1:0] coord_t;
    typedef logic [`ADDR_W-1:0]  addr_t;

    typedef struct packed {
        coord_t vga_h;
        coord_t vga_v;
    } pixel_t;

    // flag nibbles are {land, collision, hazard, at_door}
    typedef struct packed {
        coord_t     p1_x;
        coord_t     p1_y;
        coord_t     p2_x;
        coord_t     p2_y;
        logic [3:0] p1_flags;
        logic [3:0] p2_flags;
    } player_case_t;

    localparam int    CLK_HALF    = 20;
    localparam int    WAIT_LIMIT  = 200;
    localparam int    RAND_PIXELS = 300;
    localparam addr_t BLANK       = addr_t'(`BLANK_ADDR);

    // scan coordinates, the game pixel is half of each
    localparam int NUM_PIXELS = 18;
    localparam pixel_t PIXELS [NUM_PIXELS] = '{
        '{10'd10,  10'd18},   // ceiling corner above left boundary
        '{10'd10,  10'd20},   // left boundary just below ceiling
        '{10'd0,   10'd0},
        '{10'd320, 10'd464},  // red river over floor
        '{10'd440, 10'd468},  // blue river over floor
        '{10'd320, 10'd474},  // floor below the river
        '{10'd40,  10'd370},
        '{10'd200, 10'd280},
        '{10'd340, 10'd192},  // wall 3 over wall 4
        '{10'd340, 10'd180},
        '{10'd400, 10'd100},
        '{10'd520, 10'd60},
        '{10'd580, 10'd60},
        '{10'd630, 10'd200},
        '{10'd639, 10'd479},
        '{10'd100, 10'd100},  // open space
        '{10'd21,  10'd37},   // odd scan values, still open space
        '{10'd320, 10'd240}
    };

    localparam int NUM_PLAYERS = 8;
    localparam player_case_t PLAYERS [NUM_PLAYERS] = '{
        // standing on wall 1
        '{10'd50,  10'd166, 10'd100, 10'd166, 4'b1000, 4'b1000},
        // standing on the floor
        '{10'd30,  10'd214, 10'd295, 10'd214, 4'b1000, 4'b1000},
        '{10'd30,  10'd220, 10'd60,  10'd220, 4'b0100, 4'b0100},
        // each in the other colour's river
        '{10'd220, 10'd222, 10'd160, 10'd222, 4'b0110, 4'b0110},
        '{10'd160, 10'd222, 10'd220, 10'd222, 4'b0100, 4'b0100},
        '{10'd255, 10'd25,  10'd285, 10'd25,  4'b0001, 4'b0001},
        // doors swapped
        '{10'd285, 10'd25,  10'd255, 10'd25,  4'b0000, 4'b0000},
        '{10'd150, 10'd60,  10'd200, 10'd60,  4'b0000, 4'b0000}
    };

    logic   clk;
    logic   rst_n;
    logic   en;
    coord_t vga_h;
    coord_t vga_v;
    coord_t p1_x;
    coord_t p1_y;
    coord_t p2_x;
    coord_t p2_y;
    addr_t  addr;
    logic   p1_land;
    logic   p1_collision;
    logic   p1_hazard;
    logic   p1_at_door;
    logic   p2_land;
    logic   p2_collision;
    logic   p2_hazard;
    logic   p2_at_door;

    logic [7:0]  dut_flags;
    logic [31:0] lfsr_state;
    logic        en_prev;
    addr_t       last_addr;
    logic [7:0]  last_flags;
    addr_t       exp_addr_q [$];
    logic [7:0]  exp_flags_q [$];

    assign dut_flags = {p1_land, p1_collision, p1_hazard, p1_at_door,
                        p2_land, p2_collision, p2_hazard, p2_at_door};

    map_render DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .vga_h        (vga_h),
        .vga_v        (vga_v),
        .p1_x         (p1_x),
        .p1_y         (p1_y),
        .p2_x         (p2_x),
        .p2_y         (p2_y),
        .addr         (addr),
        .p1_land      (p1_land),
        .p1_collision (p1_collision),
        .p1_hazard    (p1_hazard),
        .p1_at_door   (p1_at_door),
        .p2_land      (p2_land),
        .p2_collision (p2_collision),
        .p2_hazard    (p2_hazard),
        .p2_at_door   (p2_at_door)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // polls the clock so a stopped clock cannot hang the run
    task automatic wait_fall();
        int waited;
        waited = 0;
        while (clk !== 1'b1 && waited < WAIT_LIMIT) begin
            #1;
            waited++;
        end
        while (clk !== 1'b0 && waited < WAIT_LIMIT) begin
            #1;
            waited++;
        end
        if (waited >= WAIT_LIMIT) begin
            $display("timeout, no falling clock edge within %0d ns", WAIT_LIMIT);
            stop_with_failure();
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1, right shifting form
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // first layout entry containing the game pixel sets the address
    function automatic addr_t expected_addr(input coord_t vh, input coord_t vv);
        map_layout_pkg::tile_rect_t r;
        int    gh;
        int    gv;
        int    ph;
        int    pv;
        logic  found;
        addr_t result;
        gh = int'(vh) / 2;
        gv = int'(vv) / 2;
        found = 1'b0;
        result = BLANK;
        for (int i = 0; i < `NUM_TILES; i++) begin
            r = map_layout_pkg::LAYOUT[i];
            ph = int'(r.pivot_h);
            pv = int'(r.pivot_v);
            if (!found && gh >= ph && gh < ph + int'(r.width) &&
                gv >= pv && gv < pv + int'(r.height)) begin
                result = addr_t'((gv - pv + int'(r.mem_pivot_v)) * `MEM_PITCH +
                                 (gh - ph + int'(r.mem_pivot_h)));
                found = 1'b1;
            end
        end
        return result;
    endfunction

    // player 1 is red, player 2 is blue
    function automatic logic [3:0] expected_flags(input coord_t px, input coord_t py,
                                                  input logic is_p1);
        map_layout_pkg::tile_rect_t r;
        int   x;
        int   y;
        logic ovl_h;
        logic ovl_v;
        logic land;
        logic coll;
        logic haz;
        logic door;
        x = int'(px);
        y = int'(py);
        land = 1'b0;
        coll = 1'b0;
        haz = 1'b0;
        door = 1'b0;
        for (int i = 0; i < `NUM_TILES; i++) begin
            r = map_layout_pkg::LAYOUT[i];
            ovl_h = (x < int'(r.pivot_h) + int'(r.width)) && (int'(r.pivot_h) < x + `PLAYER_W);
            ovl_v = (y < int'(r.pivot_v) + int'(r.height)) && (int'(r.pivot_v) < y + `PLAYER_H);
            if (r.kind == map_layout_pkg::TILE_SOLID) begin
                coll = coll | (ovl_h && ovl_v);
                land = land | (ovl_h && (y + `PLAYER_H == int'(r.pivot_v)));
            end
            if (r.kind == (is_p1 ? map_layout_pkg::TILE_BLUE_RIVER
                                 : map_layout_pkg::TILE_RED_RIVER)) begin
                haz = haz | (ovl_h && ovl_v);
            end
            if (r.kind == (is_p1 ? map_layout_pkg::TILE_RED_DOOR
                                 : map_layout_pkg::TILE_BLUE_DOOR)) begin
                door = door | (ovl_h && ovl_v);
            end
        end
        return {land, coll, haz, door};
    endfunction

    // one falling edge, check what the last edge produced, then drive
    task automatic clock_step(input logic en_val, input coord_t h, input coord_t v,
                              input coord_t x1, input coord_t y1,
                              input coord_t x2, input coord_t y2);
        wait_fall();
        if (DUT.u_chk.fail_count != 0) begin
            $display("an assertion on the DUT outputs failed");
            stop_with_failure();
        end
        if (en_prev) begin
            last_addr = exp_addr_q.pop_front();
            last_flags = exp_flags_q.pop_front();
        end
        check_value("addr", 32'(addr), 32'(last_addr));
        check_value("player flags", 32'(dut_flags), 32'(last_flags));
        en = en_val;
        vga_h = h;
        vga_v = v;
        p1_x = x1;
        p1_y = y1;
        p2_x = x2;
        p2_y = y2;
        if (en_val) begin
            exp_addr_q.push_back(expected_addr(h, v));
            exp_flags_q.push_back({expected_flags(x1, y1, 1'b1),
                                   expected_flags(x2, y2, 1'b0)});
        end
        en_prev = en_val;
    endtask

    task automatic random_step(input logic en_val, input logic move_players);
        logic [31:0] h;
        logic [31:0] v;
        logic [31:0] x1;
        logic [31:0] y1;
        logic [31:0] x2;
        logic [31:0] y2;
        take_bits(10, h);
        take_bits(9, v);
        if (move_players) begin
            take_bits(9, x1);
            take_bits(8, y1);
            take_bits(9, x2);
            take_bits(8, y2);
        end else begin
            x1 = 32'd150;
            y1 = 32'd60;
            x2 = 32'd200;
            y2 = 32'd60;
        end
        clock_step(en_val, coord_t'(h), coord_t'(v), coord_t'(x1), coord_t'(y1),
                   coord_t'(x2), coord_t'(y2));
    endtask

    task automatic player_step(input int k);
        player_case_t pc;
        pixel_t       px;
        pc = PLAYERS[k];
        px = PIXELS[k % NUM_PIXELS];
        check_value("reference flags for player 1", 32'(expected_flags(pc.p1_x, pc.p1_y, 1'b1)),
                    32'(pc.p1_flags));
        check_value("reference flags for player 2", 32'(expected_flags(pc.p2_x, pc.p2_y, 1'b0)),
                    32'(pc.p2_flags));
        clock_step(1'b1, px.vga_h, px.vga_v, pc.p1_x, pc.p1_y, pc.p2_x, pc.p2_y);
    endtask

    initial begin
        rst_n = 1'b0;
        en = 1'b0;
        vga_h = '0;
        vga_v = '0;
        p1_x = '0;
        p1_y = '0;
        p2_x = '0;
        p2_y = '0;
        lfsr_state = 32'hbbc0;
        en_prev = 1'b0;
        repeat (5) wait_fall();
        rst_n = 1'b1;

        // no enabled edge yet, outputs still at reset values
        wait_fall();
        check_value("addr after reset", 32'(addr), 32'(BLANK));
        check_value("flags after reset", 32'(dut_flags), 32'd0);
        last_addr = BLANK;
        last_flags = '0;
        // stage 1 leaves reset with no hit
        exp_addr_q.push_back(BLANK);

        for (int i = 0; i < NUM_PIXELS; i++) begin
            clock_step(1'b1, PIXELS[i].vga_h, PIXELS[i].vga_v,
                       10'd150, 10'd60, 10'd200, 10'd60);
        end

        // a new pixel every cycle, two in flight
        for (int i = 0; i < RAND_PIXELS; i++) begin
            random_step(1'b1, 1'b0);
        end

        for (int i = 0; i < NUM_PLAYERS; i++) begin
            player_step(i);
        end

        // stall with moving inputs, then resume
        for (int i = 0; i < 3; i++) begin
            player_step(i);
        end
        for (int i = 0; i < 6; i++) begin
            random_step(1'b0, 1'b1);
        end
        for (int i = 3; i < NUM_PLAYERS; i++) begin
            player_step(i);
        end
        for (int i = 0; i < 3; i++) begin
            clock_step(1'b1, 10'd100, 10'd100, 10'd150, 10'd60, 10'd200, 10'd60);
        end

        if (DUT.u_chk.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("an assertion on the DUT outputs failed");
            stop_with_failure();
        end
        $finish;
    end

endmodule
